//--- logic/audioPkg.sv
package audioPkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int NumChannels    = 2;
    localparam int DeltaAddrWidth = 12;
    localparam int MemDepth       = 1 << DeltaAddrWidth;
    localparam int DeltaWidth     = 12;
    localparam int SampleWidth    = 16;
    localparam int RegDataWidth   = 24;
    localparam int VolumeWidth    = 16;
    localparam int VolumeShift    = 8;
    localparam int AddressWidth   = 32;

    // intermediate width for sums and products before saturation
    localparam int WideWidth = 40;

    localparam logic signed [WideWidth-1:0] SampleMax = 2 ** (SampleWidth - 1) - 1;
    localparam logic signed [WideWidth-1:0] SampleMin = -(2 ** (SampleWidth - 1));

    // ------------------------------
    // register map and bus structs
    // ------------------------------
    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        STARTADDRESS    = 4'd1,
        SAMPLECOUNT     = 4'd2,
        LOOPSTART       = 4'd3,
        LOOPEND         = 4'd4,
        CURRENTPOSITION = 4'd5,
        LASTSAMPLE      = 4'd6,
        VOLUME          = 4'd7,
        ISLOOPING       = 4'd8,
        ISPLAYING       = 4'd9,
        ISMONO          = 4'd10,
        ISLEFT          = 4'd11
    } ChannelSettings;

    typedef struct packed {
        logic                    valid;
        logic                    channel;
        ChannelSettings          select;
        logic [RegDataWidth-1:0] data;
    } RegWrite;

    // sample is two's complement and zero while the channel is stopped
    typedef struct packed {
        logic [SampleWidth-1:0] sample;
        logic                   isMono;
        logic                   isLeft;
    } ChannelOut;

    typedef struct packed {
        logic                      valid;
        logic [DeltaAddrWidth-1:0] address;
        logic [DeltaWidth-1:0]     delta;
    } MemWrite;

    // clamp a wide signed value into the 16-bit sample range
    function automatic logic [SampleWidth-1:0] saturateSample(
        input logic signed [WideWidth-1:0] value
    );
        if (value > SampleMax) begin
            saturateSample = SampleMax[SampleWidth-1:0];
        end else if (value < SampleMin) begin
            saturateSample = SampleMin[SampleWidth-1:0];
        end else begin
            saturateSample = value[SampleWidth-1:0];
        end
    endfunction

endpackage

//--- logic/playbackChannel.sv
`timescale 1ns/1ps

module playbackChannel #(
    parameter int ChannelIndex = 0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  audioPkg::RegWrite                       i_regWrite,
    input  logic                                    i_lrclk,
    input  logic [audioPkg::DeltaWidth-1:0]         i_delta,
    input  logic                                    i_ready,
    output logic [audioPkg::AddressWidth-1:0]       o_sampleAddress,
    output audioPkg::ChannelOut                     o_channelOut
);

    // ------------------------------
    // register file
    // ------------------------------
    logic [audioPkg::RegDataWidth-1:0] startAddress;
    logic [audioPkg::RegDataWidth-1:0] sampleCount;
    logic [audioPkg::RegDataWidth-1:0] loopStart;
    logic [audioPkg::RegDataWidth-1:0] loopEnd;
    logic [audioPkg::RegDataWidth-1:0] currentPosition;
    logic [audioPkg::SampleWidth-1:0]  lastSample;
    logic [audioPkg::SampleWidth-1:0]  loopStartSample;
    logic [audioPkg::VolumeWidth-1:0]  volume;
    logic                              isLooping;
    logic                              isPlaying;
    logic                              isMono;
    logic                              isLeft;

    logic lrclkPrev;
    logic lrclkRise;
    logic writeHit;
    logic advance;
    logic loopHit;

    logic [audioPkg::RegDataWidth-1:0]    positionPlus1;
    logic [audioPkg::RegDataWidth-1:0]    nextPosition;
    logic [audioPkg::SampleWidth-1:0]     nextSample;
    logic signed [audioPkg::WideWidth-1:0] sumWide;
    logic signed [audioPkg::WideWidth-1:0] productWide;
    logic signed [audioPkg::WideWidth-1:0] scaledWide;

    logic [audioPkg::AddressWidth-1:0] addressMono;
    logic [audioPkg::AddressWidth-1:0] addressLeft;
    logic [audioPkg::AddressWidth-1:0] addressRight;

    assign writeHit  = i_regWrite.valid && (i_regWrite.channel == 1'(ChannelIndex));
    assign lrclkRise = i_lrclk && !lrclkPrev;

    // a channel only steps while playing and with a valid word from memory
    assign advance = lrclkRise && isPlaying && i_ready;

    // ------------------------------
    // position and delta decoding
    // ------------------------------
    assign positionPlus1 = currentPosition + 1'b1;
    assign loopHit       = isLooping && (positionPlus1 >= loopEnd);
    assign nextPosition  = loopHit ? loopStart : positionPlus1;

    // the stored delta is doubled before it is integrated
    assign sumWide    = $signed(lastSample) + $signed({i_delta, 1'b0});
    assign nextSample = loopHit ? loopStartSample : audioPkg::saturateSample(sumWide);

    // stereo pairs are interleaved, so each side skips every other word
    assign addressMono  = audioPkg::AddressWidth'(startAddress)
                        + audioPkg::AddressWidth'(currentPosition) + 32'd1;
    assign addressLeft  = audioPkg::AddressWidth'(startAddress)
                        + (audioPkg::AddressWidth'(currentPosition) << 1) + 32'd2;
    assign addressRight = audioPkg::AddressWidth'(startAddress)
                        + (audioPkg::AddressWidth'(currentPosition) << 1) + 32'd3;

    assign o_sampleAddress = isMono ? addressMono : (isLeft ? addressLeft : addressRight);

    // ------------------------------
    // volume
    // ------------------------------
    assign productWide = $signed(lastSample) * $signed({1'b0, volume});
    assign scaledWide  = productWide >>> audioPkg::VolumeShift;

    assign o_channelOut.sample = isPlaying ? audioPkg::saturateSample(scaledWide) : '0;
    assign o_channelOut.isMono = isMono;
    assign o_channelOut.isLeft = isLeft;

    always_ff @(posedge clk) begin
        if (rst) begin
            lrclkPrev <= 1'b0;
        end else begin
            lrclkPrev <= i_lrclk;
        end
    end

    // host writes land after the lrclk step so they win in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            currentPosition <= '0;
            lastSample      <= '0;
        end else begin
            if (advance) begin
                currentPosition <= nextPosition;
                lastSample      <= nextSample;
            end
            if (writeHit && i_regWrite.select == audioPkg::CURRENTPOSITION) begin
                currentPosition <= i_regWrite.data;
            end
            if (writeHit && i_regWrite.select == audioPkg::LASTSAMPLE) begin
                lastSample <= i_regWrite.data[audioPkg::SampleWidth-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            startAddress <= '0;
            sampleCount  <= '0;
            loopStart    <= '0;
            loopEnd      <= '0;
            volume       <= '0;
            isLooping    <= 1'b0;
            isPlaying    <= 1'b0;
            isMono       <= 1'b0;
            isLeft       <= 1'b0;
        end else begin
            if (writeHit) begin
                case (i_regWrite.select)
                    audioPkg::STARTADDRESS: startAddress <= i_regWrite.data;
                    audioPkg::SAMPLECOUNT:  sampleCount  <= i_regWrite.data;
                    audioPkg::LOOPSTART:    loopStart    <= i_regWrite.data;
                    audioPkg::LOOPEND:      loopEnd      <= i_regWrite.data;
                    audioPkg::VOLUME: volume <= i_regWrite.data[audioPkg::VolumeWidth-1:0];
                    audioPkg::ISLOOPING:    isLooping    <= i_regWrite.data[0];
                    audioPkg::ISPLAYING:    isPlaying    <= i_regWrite.data[0];
                    audioPkg::ISMONO:       isMono       <= i_regWrite.data[0];
                    audioPkg::ISLEFT:       isLeft       <= i_regWrite.data[0];
                    default: ;
                endcase
            end
            // the end of the sample always stops playback
            if (currentPosition >= sampleCount) begin
                isPlaying <= 1'b0;
            end
        end
    end

    // the sample seen at the loop start is replayed when the loop wraps
    always_ff @(posedge clk) begin
        if (currentPosition == loopStart) begin
            loopStartSample <= lastSample;
        end
    end

endmodule

//--- logic/deltaMemory.sv
`timescale 1ns/1ps

module deltaMemory (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  audioPkg::MemWrite                                       i_memWrite,
    input  logic [audioPkg::NumChannels-1:0][audioPkg::DeltaAddrWidth-1:0] i_readAddress,
    output logic [audioPkg::NumChannels-1:0][audioPkg::DeltaWidth-1:0]     o_delta,
    output logic [audioPkg::NumChannels-1:0]                        o_ready
);

    logic [audioPkg::DeltaWidth-1:0] mem [audioPkg::MemDepth];

    logic [audioPkg::NumChannels-1:0][audioPkg::DeltaAddrWidth-1:0] lastAddress;
    logic [audioPkg::NumChannels-1:0][audioPkg::DeltaWidth-1:0]     readData;
    logic [audioPkg::NumChannels-1:0]                               readValid;

    // ------------------------------
    // host write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_memWrite.valid) begin
            mem[i_memWrite.address] <= i_memWrite.delta;
        end
    end

    // ------------------------------
    // read ports
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int port = 0; port < audioPkg::NumChannels; port++) begin
            readData[port] <= mem[i_readAddress[port]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lastAddress <= '0;
            readValid   <= '0;
        end else begin
            lastAddress <= i_readAddress;
            readValid   <= '1;
        end
    end

    // ready drops as soon as a port moves to a new address
    always_comb begin
        for (int port = 0; port < audioPkg::NumChannels; port++) begin
            o_ready[port] = readValid[port] && (lastAddress[port] == i_readAddress[port]);
        end
    end

    assign o_delta = readData;

endmodule

//--- logic/channelMixer.sv
`timescale 1ns/1ps

module channelMixer (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_lrclk,
    input  audioPkg::ChannelOut [audioPkg::NumChannels-1:0] i_channelOut,
    output logic [audioPkg::SampleWidth-1:0]               o_left,
    output logic [audioPkg::SampleWidth-1:0]               o_right
);

    logic lrclkPrev;
    logic lrclkRise;

    logic signed [audioPkg::WideWidth-1:0] leftSum;
    logic signed [audioPkg::WideWidth-1:0] rightSum;

    assign lrclkRise = i_lrclk && !lrclkPrev;

    always_ff @(posedge clk) begin
        if (rst) begin
            lrclkPrev <= 1'b0;
        end else begin
            lrclkPrev <= i_lrclk;
        end
    end

    // ------------------------------
    // routing and summing
    // ------------------------------
    // mono channels feed both sides, stereo channels only their own
    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int ch = 0; ch < audioPkg::NumChannels; ch++) begin
            if (i_channelOut[ch].isMono || i_channelOut[ch].isLeft) begin
                leftSum = leftSum + $signed(i_channelOut[ch].sample);
            end
            if (i_channelOut[ch].isMono || !i_channelOut[ch].isLeft) begin
                rightSum = rightSum + $signed(i_channelOut[ch].sample);
            end
        end
    end

    // ------------------------------
    // output latch
    // ------------------------------
    // channels update on this same clock edge, so the latched values are
    // the samples from before their step
    always_ff @(posedge clk) begin
        if (rst) begin
            o_left  <= '0;
            o_right <= '0;
        end else if (lrclkRise) begin
            o_left  <= audioPkg::saturateSample(leftSum);
            o_right <= audioPkg::saturateSample(rightSum);
        end
    end

endmodule

//--- logic/sampleEngine.sv
`timescale 1ns/1ps

module sampleEngine (
    input  logic                             clk,
    input  logic                             rst,
    input  audioPkg::RegWrite                i_regWrite,
    input  audioPkg::MemWrite                i_memWrite,
    input  logic                             i_lrclk,
    output logic [audioPkg::SampleWidth-1:0] o_left,
    output logic [audioPkg::SampleWidth-1:0] o_right
);

    // ------------------------------
    // interconnect
    // ------------------------------
    logic [audioPkg::NumChannels-1:0][audioPkg::AddressWidth-1:0]   sampleAddress;
    logic [audioPkg::NumChannels-1:0][audioPkg::DeltaAddrWidth-1:0] readAddress;
    logic [audioPkg::NumChannels-1:0][audioPkg::DeltaWidth-1:0]     delta;
    logic [audioPkg::NumChannels-1:0]                               ready;
    audioPkg::ChannelOut [audioPkg::NumChannels-1:0]                channelOut;

    // ------------------------------
    // producers
    // ------------------------------
    for (genvar ch = 0; ch < audioPkg::NumChannels; ch++) begin : genChannel
        playbackChannel #(
            .ChannelIndex(ch)
        ) channel_inst (
            .clk             (clk),
            .rst             (rst),
            .i_regWrite      (i_regWrite),
            .i_lrclk         (i_lrclk),
            .i_delta         (delta[ch]),
            .i_ready         (ready[ch]),
            .o_sampleAddress (sampleAddress[ch]),
            .o_channelOut    (channelOut[ch])
        );

        // the memory only decodes the low address bits
        assign readAddress[ch] = sampleAddress[ch][audioPkg::DeltaAddrWidth-1:0];
    end

    // ------------------------------
    // shared delta store
    // ------------------------------
    deltaMemory deltaMemory_inst (
        .clk           (clk),
        .rst           (rst),
        .i_memWrite    (i_memWrite),
        .i_readAddress (readAddress),
        .o_delta       (delta),
        .o_ready       (ready)
    );

    // ------------------------------
    // consumer
    // ------------------------------
    channelMixer channelMixer_inst (
        .clk          (clk),
        .rst          (rst),
        .i_lrclk      (i_lrclk),
        .i_channelOut (channelOut),
        .o_left       (o_left),
        .o_right      (o_right)
    );

endmodule

//--- verification/sampleEngine_checker.sv
`timescale 1ns/1ps

module sampleEngine_checker (
    input logic        clk,
    input logic        rst,
    input logic        i_playing,
    input logic [23:0] i_position,
    input logic [23:0] i_sampleCount,
    input logic [15:0] i_left,
    input logic [15:0] i_right,
    input logic [11:0] i_address,
    input logic        i_ready
);

    // ------------------------------
    // channel rules
    // ------------------------------
    // playback stops once the position reaches the sample count
    positionInRange: assert property (
        @(posedge clk) disable iff (rst)
        i_playing |-> (i_position <= i_sampleCount)
    ) else $error("position passed the sample count while playing");

    // the memory word needs a stable address before it counts as ready
    readyAfterAddress: assert property (
        @(posedge clk) disable iff (rst)
        $changed(i_address) |-> !$rose(i_ready)
    ) else $error("ready rose in the same cycle as an address change");

    // ------------------------------
    // reset values
    // ------------------------------
    outputsClearAfterReset: assert property (
        @(posedge clk)
        $fell(rst) |-> (i_left == 16'd0 && i_right == 16'd0)
    ) else $error("outputs not zero in the first cycle after reset");

endmodule

bind playbackChannel sampleEngine_checker checker_inst (
    .clk           (clk),
    .rst           (rst),
    .i_playing     (isPlaying),
    .i_position    (currentPosition),
    .i_sampleCount (sampleCount),
    .i_left        (o_channelOut.sample),
    .i_right       (16'd0),
    .i_address     (o_sampleAddress[11:0]),
    .i_ready       (i_ready)
);

bind channelMixer sampleEngine_checker checker_inst (
    .clk           (clk),
    .rst           (rst),
    .i_playing     (1'b0),
    .i_position    (24'd0),
    .i_sampleCount (24'd0),
    .i_left        (o_left),
    .i_right       (o_right),
    .i_address     (12'd0),
    .i_ready       (1'b0)
);

//--- verification/sampleEngineTb.sv
`timescale 1ns/1ps

module sampleEngineTb;

    localparam logic [1:0] RowReg    = 2'd0;
    localparam logic [1:0] RowMem    = 2'd1;
    localparam logic [1:0] RowFrames = 2'd2;
    localparam int         FillWords = 128;

    typedef struct packed {
        logic [1:0]              kind;
        logic                    channel;
        audioPkg::ChannelSettings select;
        logic [23:0]             data;
        logic [11:0]             address;
    } StimRow;

    logic clk;
    logic rst;
    logic i_lrclk;
    audioPkg::RegWrite i_regWrite;
    audioPkg::MemWrite i_memWrite;
    logic [15:0] o_left;
    logic [15:0] o_right;

    StimRow stimTable[$];
    logic [11:0] memModel [4096];
    int mStart [2];
    int mCount [2];
    int mLoopStart [2];
    int mLoopEnd [2];
    int mPos [2];
    int mLast [2];
    int mLoopSample [2];
    int mVolume [2];
    bit mLooping [2];
    bit mPlaying [2];
    bit mMono [2];
    bit mLeft [2];

    integer seed;
    int errorCount;
    int cycleCount;
    int cycleLimit;

    sampleEngine sampleEngine_inst (
        .clk        (clk),
        .rst        (rst),
        .i_regWrite (i_regWrite),
        .i_memWrite (i_memWrite),
        .i_lrclk    (i_lrclk),
        .o_left     (o_left),
        .o_right    (o_right)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int clampSample(longint value);
        if (value > 32767) return 32767;
        if (value < -32768) return -32768;
        return int'(value);
    endfunction

    function automatic int scaledSample(int ch);
        if (!mPlaying[ch]) return 0;
        return clampSample((longint'(mLast[ch]) * longint'(mVolume[ch])) >>> 8);
    endfunction

    function automatic int readAddress(int ch);
        int addr;
        if (mMono[ch]) addr = mStart[ch] + mPos[ch] + 1;
        else if (mLeft[ch]) addr = mStart[ch] + 2 * mPos[ch] + 2;
        else addr = mStart[ch] + 2 * mPos[ch] + 3;
        return addr & 12'hfff;
    endfunction

    // loop-start capture and end-of-sample stop hold in every cycle
    function automatic void settleChannel(int ch);
        if (mPos[ch] == mLoopStart[ch]) mLoopSample[ch] = mLast[ch];
        if (mPos[ch] >= mCount[ch]) mPlaying[ch] = 1'b0;
    endfunction

    function automatic void writeModel(int ch, audioPkg::ChannelSettings sel, logic [23:0] data);
        case (sel)
            audioPkg::STARTADDRESS:    mStart[ch] = int'(data);
            audioPkg::SAMPLECOUNT:     mCount[ch] = int'(data);
            audioPkg::LOOPSTART:       mLoopStart[ch] = int'(data);
            audioPkg::LOOPEND:         mLoopEnd[ch] = int'(data);
            audioPkg::CURRENTPOSITION: mPos[ch] = int'(data);
            audioPkg::LASTSAMPLE:      mLast[ch] = int'($signed(data[15:0]));
            audioPkg::VOLUME:          mVolume[ch] = int'(data[15:0]);
            audioPkg::ISLOOPING:       mLooping[ch] = data[0];
            audioPkg::ISPLAYING:       mPlaying[ch] = data[0];
            audioPkg::ISMONO:          mMono[ch] = data[0];
            audioPkg::ISLEFT:          mLeft[ch] = data[0];
            default: ;
        endcase
        settleChannel(ch);
    endfunction

    function automatic void stepChannels();
        int delta;
        for (int ch = 0; ch < 2; ch++) begin
            if (mPlaying[ch]) begin
                delta = int'($signed(memModel[readAddress(ch)]));
                if (mLooping[ch] && mPos[ch] + 1 >= mLoopEnd[ch]) begin
                    mPos[ch] = mLoopStart[ch];
                    mLast[ch] = mLoopSample[ch];
                end else begin
                    mPos[ch] = mPos[ch] + 1;
                    mLast[ch] = clampSample(longint'(mLast[ch]) + 2 * delta);
                end
            end
            settleChannel(ch);
        end
    endfunction

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic addReg(int ch, audioPkg::ChannelSettings sel, logic [23:0] data);
        stimTable.push_back(StimRow'{RowReg, ch[0], sel, data, 12'd0});
    endtask

    task automatic addMem(int addr, logic [11:0] delta);
        stimTable.push_back(StimRow'{RowMem, 1'b0, audioPkg::IDLE, {12'd0, delta}, addr[11:0]});
    endtask

    task automatic addFrames(int count);
        stimTable.push_back(StimRow'{RowFrames, 1'b0, audioPkg::IDLE, count[23:0], 12'd0});
    endtask

    task automatic buildTable();
        // large positive then large negative deltas for the saturation run
        for (int a = 65; a <= 68; a++) addMem(a, 12'h7ff);
        for (int a = 69; a <= 72; a++) addMem(a, 12'h800);
        // mono playback that runs off its sample count
        addReg(0, audioPkg::STARTADDRESS, 0);
        addReg(0, audioPkg::SAMPLECOUNT, 10);
        addReg(0, audioPkg::VOLUME, 256);
        addReg(0, audioPkg::ISMONO, 1);
        addReg(0, audioPkg::ISPLAYING, 1);
        addFrames(12);
        // restart from a written position and sample and hit both rails
        addReg(0, audioPkg::STARTADDRESS, 64);
        addReg(0, audioPkg::CURRENTPOSITION, 0);
        addReg(0, audioPkg::LASTSAMPLE, 30000);
        addReg(0, audioPkg::SAMPLECOUNT, 8);
        addReg(0, audioPkg::ISPLAYING, 1);
        addFrames(4);
        addReg(0, audioPkg::CURRENTPOSITION, 4);
        addReg(0, audioPkg::LASTSAMPLE, 24'h008ad0);
        addFrames(4);
        // stereo pair
        addReg(0, audioPkg::STARTADDRESS, 0);
        addReg(0, audioPkg::CURRENTPOSITION, 0);
        addReg(0, audioPkg::LASTSAMPLE, 0);
        addReg(0, audioPkg::ISMONO, 0);
        addReg(0, audioPkg::ISLEFT, 1);
        addReg(0, audioPkg::VOLUME, 128);
        addReg(0, audioPkg::SAMPLECOUNT, 16);
        addReg(0, audioPkg::ISPLAYING, 1);
        addReg(1, audioPkg::ISLEFT, 0);
        addReg(1, audioPkg::VOLUME, 200);
        addReg(1, audioPkg::SAMPLECOUNT, 16);
        addReg(1, audioPkg::ISPLAYING, 1);
        addFrames(8);
        addReg(0, audioPkg::ISPLAYING, 0);
        addReg(1, audioPkg::ISPLAYING, 0);
        // looping mono channel
        addReg(1, audioPkg::ISMONO, 1);
        addReg(1, audioPkg::STARTADDRESS, 40);
        addReg(1, audioPkg::CURRENTPOSITION, 0);
        addReg(1, audioPkg::LASTSAMPLE, 1000);
        addReg(1, audioPkg::LOOPSTART, 2);
        addReg(1, audioPkg::LOOPEND, 6);
        addReg(1, audioPkg::ISLOOPING, 1);
        addReg(1, audioPkg::SAMPLECOUNT, 100);
        addReg(1, audioPkg::VOLUME, 256);
        addReg(1, audioPkg::ISPLAYING, 1);
        addFrames(12);
        addReg(1, audioPkg::ISPLAYING, 0);
        addReg(1, audioPkg::ISLOOPING, 0);
        // two mono channels summed past both rails
        addReg(0, audioPkg::ISMONO, 1);
        addReg(0, audioPkg::VOLUME, 256);
        addReg(0, audioPkg::STARTADDRESS, 64);
        addReg(0, audioPkg::CURRENTPOSITION, 0);
        addReg(0, audioPkg::SAMPLECOUNT, 8);
        addReg(0, audioPkg::LASTSAMPLE, 30000);
        addReg(0, audioPkg::ISPLAYING, 1);
        addReg(1, audioPkg::STARTADDRESS, 80);
        addReg(1, audioPkg::CURRENTPOSITION, 0);
        addReg(1, audioPkg::SAMPLECOUNT, 8);
        addReg(1, audioPkg::LASTSAMPLE, 25000);
        addReg(1, audioPkg::ISPLAYING, 1);
        addFrames(2);
        addReg(0, audioPkg::LASTSAMPLE, 24'h008ad0);
        addReg(1, audioPkg::LASTSAMPLE, 24'h009e58);
        addFrames(2);
    endtask

    // ------------------------------
    // drivers and checks
    // ------------------------------
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkOutputs(logic [15:0] expLeft, logic [15:0] expRight);
        assert (o_left === expLeft) else begin
            $display("Error: t=%0t o_left expected %0d actual %0d",
                     $time, $signed(expLeft), $signed(o_left));
            errorCount++;
        end
        assert (o_right === expRight) else begin
            $display("Error: t=%0t o_right expected %0d actual %0d",
                     $time, $signed(expRight), $signed(o_right));
            errorCount++;
        end
    endtask

    // one frame is 16 clocks with lrclk low for the first half
    task automatic playFrame();
        longint sumLeft;
        longint sumRight;
        logic [15:0] expLeft;
        logic [15:0] expRight;
        repeat (8) nextCycle();
        i_lrclk = 1'b1;
        sumLeft = 0;
        sumRight = 0;
        for (int ch = 0; ch < 2; ch++) begin
            if (mMono[ch] || mLeft[ch]) sumLeft += scaledSample(ch);
            if (mMono[ch] || !mLeft[ch]) sumRight += scaledSample(ch);
        end
        expLeft = 16'(clampSample(sumLeft));
        expRight = 16'(clampSample(sumRight));
        stepChannels();
        nextCycle();
        checkOutputs(expLeft, expRight);
        repeat (7) nextCycle();
        i_lrclk = 1'b0;
    endtask

    initial begin
        int frames;
        rst = 1'b1;
        i_lrclk = 1'b0;
        i_regWrite = '0;
        i_memWrite = '0;
        errorCount = 0;
        seed = 32'hccff_ed06;
        for (int ch = 0; ch < 2; ch++) begin
            {mStart[ch], mCount[ch], mLoopStart[ch], mLoopEnd[ch]} = '0;
            {mPos[ch], mLast[ch], mLoopSample[ch], mVolume[ch]} = '0;
            {mLooping[ch], mPlaying[ch], mMono[ch], mLeft[ch]} = '0;
        end
        buildTable();
        frames = 0;
        foreach (stimTable[i]) begin
            if (stimTable[i].kind == RowFrames) frames += int'(stimTable[i].data);
        end
        cycleLimit = 16 * frames + stimTable.size() + FillWords + 4 + 200;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int a = 0; a < FillWords; a++) begin
            i_memWrite.valid = 1'b1;
            i_memWrite.address = a[11:0];
            i_memWrite.delta = 12'($random(seed));
            memModel[a] = i_memWrite.delta;
            nextCycle();
        end
        i_memWrite = '0;

        foreach (stimTable[i]) begin
            case (stimTable[i].kind)
                RowReg: begin
                    i_regWrite.valid = 1'b1;
                    i_regWrite.channel = stimTable[i].channel;
                    i_regWrite.select = stimTable[i].select;
                    i_regWrite.data = stimTable[i].data;
                    writeModel(int'(stimTable[i].channel), stimTable[i].select,
                               stimTable[i].data);
                    nextCycle();
                    i_regWrite = '0;
                end
                RowMem: begin
                    i_memWrite.valid = 1'b1;
                    i_memWrite.address = stimTable[i].address;
                    i_memWrite.delta = stimTable[i].data[11:0];
                    memModel[stimTable[i].address] = stimTable[i].data[11:0];
                    nextCycle();
                    i_memWrite = '0;
                end
                default: begin
                    repeat (int'(stimTable[i].data)) playFrame();
                end
            endcase
        end

        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // the watchdog arms once the table length is known
    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
logic/audioPkg.sv
logic/playbackChannel.sv
logic/deltaMemory.sv
logic/channelMixer.sv
logic/sampleEngine.sv
verification/sampleEngine_checker.sv
verification/sampleEngineTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module sampleEngineTb -f compile.f

output=$(./obj_dir/VsampleEngineTb)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi
